//--- Bender.yml
package:
  name: fm_core

sources:
  - source/fm_pkg.sv
  - source/fm_delay.sv
  - source/fm_phase_gen.sv
  - source/fm_logsin_rom.sv
  - source/fm_exp_rom.sv
  - source/fm_operator.sv
  - source/fm_mixer.sv
  - source/fm_core.sv
  - target: test
    files:
      - verification/fm_core_sva.sv
      - verification/fm_core_tb.sv

//--- all.f
source/fm_pkg.sv
source/fm_delay.sv
source/fm_phase_gen.sv
source/fm_logsin_rom.sv
source/fm_exp_rom.sv
source/fm_operator.sv
source/fm_mixer.sv
source/fm_core.sv
verification/fm_core_sva.sv
verification/fm_core_tb.sv

//--- source/fm_core.sv
/*
 * Two-voice FM tone generator core
 * Phase generator feeding the shared operator, carriers mixed per frame
 */
`timescale 1ns/100ps

module fm_core (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            cen,
    input  logic                            cfg_we,
    input  logic [fm_pkg::SLOT_W-1:0]       cfg_slot,
    input  logic [fm_pkg::FREQ_W-1:0]       cfg_freq,
    input  logic [fm_pkg::ATT_W-1:0]        cfg_att,
    input  logic [fm_pkg::FB_W-1:0]         cfg_fb,
    output logic signed [fm_pkg::SMP_W-1:0] sample,
    output logic                            sample_valid,
    output logic signed [fm_pkg::OUT_W-1:0] op_out,
    output logic [fm_pkg::SLOT_W-1:0]       op_slot
);

    // Entering slot, one tick after the counter
    logic [fm_pkg::SLOT_W-1:0]  pg_slot;
    logic [fm_pkg::PHASE_W-1:0] pg_phase;
    logic [fm_pkg::ATT_W-1:0]   pg_att;
    logic [fm_pkg::FB_W-1:0]    pg_fb;

    fm_phase_gen u_phase_gen (
        .clk     (clk),
        .rst_n   (rst_n),
        .cen     (cen),
        .cfg_we  (cfg_we),
        .cfg_slot(cfg_slot),
        .cfg_freq(cfg_freq),
        .cfg_att (cfg_att),
        .cfg_fb  (cfg_fb),
        .slot    (pg_slot),
        .phase   (pg_phase),
        .att     (pg_att),
        .fb      (pg_fb)
    );

    fm_operator u_operator (
        .clk    (clk),
        .rst_n  (rst_n),
        .cen    (cen),
        .slot   (pg_slot),
        .phase  (pg_phase),
        .att    (pg_att),
        .fb     (pg_fb),
        .op_out (op_out),
        .op_slot(op_slot)
    );

    fm_mixer u_mixer (
        .clk         (clk),
        .rst_n       (rst_n),
        .cen         (cen),
        .op_out      (op_out),
        .op_slot     (op_slot),
        .sample      (sample),
        .sample_valid(sample_valid)
    );

endmodule

//--- source/fm_delay.sv
/*
 * Clock-enabled delay line
 * Parameterized width and depth, cleared on reset
 */
`timescale 1ns/100ps

module fm_delay #(
    parameter int WIDTH = 1,
    parameter int DEPTH = 1
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             cen,
    input  logic [WIDTH-1:0] din,
    output logic [WIDTH-1:0] dout
);

    logic [WIDTH-1:0] stages [DEPTH];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                stages[i] <= '0;
            end
        end else if (cen) begin
            stages[0] <= din;
            // Shift toward the output end
            for (int i = 1; i < DEPTH; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    assign dout = stages[DEPTH-1];

endmodule

//--- source/fm_exp_rom.sv
/*
 * Exponential mantissa ROM
 * 256 entries of 2^(-i/256) fraction, registered read
 */
`timescale 1ns/100ps

module fm_exp_rom (
    input  logic                      clk,
    input  logic                      cen,
    input  logic [fm_pkg::ROM_AW-1:0] addr,
    output logic [fm_pkg::MANT_W-1:0] mant
);

    logic [fm_pkg::MANT_W-1:0] rom_data [2**fm_pkg::ROM_AW];

    // Indexed by the fine part of the total attenuation
    for (genvar i = 0; i < 2**fm_pkg::ROM_AW; i++) begin : g_fill
        assign rom_data[i] = fm_pkg::exp_entry(i);
    end

    // Registered lookup, same timing as the log-sine table
    always_ff @(posedge clk) begin
        if (cen) begin
            mant <= rom_data[addr];
        end
    end

endmodule

//--- source/fm_logsin_rom.sv
/*
 * Quarter-wave log-sine ROM
 * 256 entries built from the package function, registered read
 */
`timescale 1ns/100ps

module fm_logsin_rom (
    input  logic                      clk,
    input  logic                      cen,
    input  logic [fm_pkg::ROM_AW-1:0] addr,
    output logic [fm_pkg::LOG_W-1:0]  logsin
);

    logic [fm_pkg::LOG_W-1:0] rom_data [2**fm_pkg::ROM_AW];

    // Constant contents, one entry per quarter-wave index
    for (genvar i = 0; i < 2**fm_pkg::ROM_AW; i++) begin : g_fill
        assign rom_data[i] = fm_pkg::logsin_entry(i);
    end

    // Output register holds while cen is low
    always_ff @(posedge clk) begin
        if (cen) begin
            logsin <= rom_data[addr];
        end
    end

endmodule

//--- source/fm_mixer.sv
/*
 * Carrier mixer
 * Adds both carrier outputs of a frame, saturates to the sample
 * width and flags each new sample with a one-clock pulse
 */
`timescale 1ns/100ps

module fm_mixer (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            cen,
    input  logic signed [fm_pkg::OUT_W-1:0] op_out,
    input  logic [fm_pkg::SLOT_W-1:0]       op_slot,
    output logic signed [fm_pkg::SMP_W-1:0] sample,
    output logic                            sample_valid
);

    // Voice 0 carrier of the current frame
    logic signed [fm_pkg::OUT_W-1:0] carrier0;
    logic signed [fm_pkg::SMP_W:0]   sum;
    logic signed [fm_pkg::SMP_W-1:0] sum_sat;

    always_comb begin
        sum = (fm_pkg::SMP_W + 1)'(carrier0) + (fm_pkg::SMP_W + 1)'(op_out);
        // Overflow when the two top bits disagree
        if (sum[fm_pkg::SMP_W] != sum[fm_pkg::SMP_W-1]) begin
            sum_sat = sum[fm_pkg::SMP_W] ? {1'b1, {(fm_pkg::SMP_W - 1){1'b0}}}
                                         : {1'b0, {(fm_pkg::SMP_W - 1){1'b1}}};
        end else begin
            sum_sat = sum[fm_pkg::SMP_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            carrier0     <= '0;
            sample       <= '0;
            sample_valid <= 1'b0;
        end else begin
            // Pulse lasts one clock, stalls included
            sample_valid <= 1'b0;
            if (cen) begin
                if (op_slot == fm_pkg::SLOT_W'(1)) begin
                    carrier0 <= op_out;
                end
                // Voice 1 carrier closes the frame
                if (op_slot == fm_pkg::SLOT_W'(fm_pkg::NUM_SLOTS - 1)) begin
                    sample       <= sum_sat;
                    sample_valid <= 1'b1;
                end
            end
        end
    end

endmodule

//--- source/fm_operator.sv
/*
 * Time-multiplexed sine operator
 * Five ticks from phase to signed output: modulation, phase add,
 * log-sine lookup, attenuation and exp lookup, shift and sign
 */
`timescale 1ns/100ps

module fm_operator (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              cen,
    input  logic [fm_pkg::SLOT_W-1:0]         slot,
    input  logic [fm_pkg::PHASE_W-1:0]        phase,
    input  logic [fm_pkg::ATT_W-1:0]          att,
    input  logic [fm_pkg::FB_W-1:0]           fb,
    output logic signed [fm_pkg::OUT_W-1:0]   op_out,
    output logic [fm_pkg::SLOT_W-1:0]         op_slot
);

    // Stage 5 result and history
    logic signed [fm_pkg::OUT_W-1:0] op_next;
    logic signed [fm_pkg::OUT_W-1:0] hist;
    logic signed [fm_pkg::OUT_W:0]   fb_sum;
    logic signed [fm_pkg::OUT_W:0]   fb_shifted;
    logic [fm_pkg::PHASE_W-1:0]      mod;
    // Stage 1
    logic [fm_pkg::PHASE_W-1:0]      phase_s1;
    logic [fm_pkg::PHASE_W-1:0]      mod_s1;
    logic [fm_pkg::ATT_W-1:0]        att_s1;
    // Stage 2
    logic [fm_pkg::PHASE_W-1:0]      phase_sum;
    logic [fm_pkg::ROM_AW-1:0]       qidx;
    logic [fm_pkg::ROM_AW-1:0]       qidx_s2;
    logic [fm_pkg::ATT_W-1:0]        att_s2;
    // Stage 3
    logic [fm_pkg::LOG_W-1:0]        logsin_s3;
    logic [fm_pkg::ATT_W-1:0]        att_s3;
    // Stage 4
    logic [fm_pkg::LOG_W:0]          tot_raw;
    logic [fm_pkg::LOG_W-1:0]        tot_att;
    logic [fm_pkg::MANT_W-1:0]       mant_s4;
    logic [3:0]                      exp_s4;
    logic                            sign_s4;
    // Stage 5
    logic [fm_pkg::MANT_W:0]         mag;
    // Ticks since reset, saturates once the pipeline is full
    logic [2:0]                      fill;

    // Completed outputs, back at stage 1 two frames later
    fm_delay #(.WIDTH(fm_pkg::OUT_W), .DEPTH(fm_pkg::NUM_SLOTS)) u_hist (
        .clk  (clk),
        .rst_n(rst_n),
        .cen  (cen),
        .din  (op_next),
        .dout (hist)
    );

    // Stage 1, op_next is this slot's own previous-frame output
    always_comb begin
        fb_sum     = {op_next[fm_pkg::OUT_W-1], op_next} + {hist[fm_pkg::OUT_W-1], hist};
        fb_shifted = fb_sum >>> (4'd10 - 4'(fb));
        if (slot[0]) begin
            // Carrier, op_out holds its modulator from the last frame
            mod = op_out[fm_pkg::PHASE_W:1];
        end else if (fb == '0) begin
            mod = '0;
        end else begin
            mod = fb_shifted[fm_pkg::PHASE_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (cen) begin
            phase_s1 <= phase;
            mod_s1   <= mod;
            att_s1   <= att;
        end
    end

    // Stage 2, modulated phase and mirrored quarter-wave index
    always_comb begin
        phase_sum = phase_s1 + mod_s1;
        qidx      = phase_sum[fm_pkg::ROM_AW] ? ~phase_sum[fm_pkg::ROM_AW-1:0]
                                               : phase_sum[fm_pkg::ROM_AW-1:0];
    end

    always_ff @(posedge clk) begin
        if (cen) begin
            qidx_s2 <= qidx;
            att_s2  <= att_s1;
        end
    end

    // Sign bit waits out stages 2 to 4
    fm_delay #(.WIDTH(1), .DEPTH(3)) u_sign (
        .clk  (clk),
        .rst_n(rst_n),
        .cen  (cen),
        .din  (phase_sum[fm_pkg::PHASE_W-1]),
        .dout (sign_s4)
    );

    // Stage 3
    fm_logsin_rom u_logsin_rom (
        .clk   (clk),
        .cen   (cen),
        .addr  (qidx_s2),
        .logsin(logsin_s3)
    );

    always_ff @(posedge clk) begin
        if (cen) begin
            att_s3 <= att_s2;
        end
    end

    // Stage 4, total attenuation clipped at full scale
    always_comb begin
        tot_raw = {1'b0, logsin_s3} + {1'b0, att_s3, 2'b00};
        tot_att = tot_raw[fm_pkg::LOG_W] ? '1 : tot_raw[fm_pkg::LOG_W-1:0];
    end

    fm_exp_rom u_exp_rom (
        .clk (clk),
        .cen (cen),
        .addr(tot_att[fm_pkg::ROM_AW-1:0]),
        .mant(mant_s4)
    );

    always_ff @(posedge clk) begin
        if (cen) begin
            exp_s4 <= tot_att[fm_pkg::LOG_W-1 -: 4];
        end
    end

    // Stage 5, hidden bit plus mantissa shifted by exponent + 1
    always_comb begin
        mag = {1'b1, mant_s4} >> (5'(exp_s4) + 5'd1);
        // Nothing real reaches stage 5 before OP_LATENCY ticks
        if (fill != 3'(fm_pkg::OP_LATENCY)) begin
            op_next = '0;
        end else if (sign_s4) begin
            op_next = -fm_pkg::OUT_W'(mag);
        end else begin
            op_next = fm_pkg::OUT_W'(mag);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fill   <= '0;
            op_out <= '0;
        end else if (cen) begin
            op_out <= op_next;
            if (fill != 3'(fm_pkg::OP_LATENCY)) begin
                fill <= fill + 3'd1;
            end
        end
    end

    // Slot number rides alongside the data
    fm_delay #(.WIDTH(fm_pkg::SLOT_W), .DEPTH(fm_pkg::OP_LATENCY)) u_slot (
        .clk  (clk),
        .rst_n(rst_n),
        .cen  (cen),
        .din  (slot),
        .dout (op_slot)
    );

endmodule

//--- source/fm_phase_gen.sv
/*
 * Phase generator
 * Free-running slot counter, per-slot settings written by strobe,
 * and one phase accumulator per slot stepped once per frame
 */
`timescale 1ns/100ps

module fm_phase_gen (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cen,
    input  logic                       cfg_we,
    input  logic [fm_pkg::SLOT_W-1:0]  cfg_slot,
    input  logic [fm_pkg::FREQ_W-1:0]  cfg_freq,
    input  logic [fm_pkg::ATT_W-1:0]   cfg_att,
    input  logic [fm_pkg::FB_W-1:0]    cfg_fb,
    output logic [fm_pkg::SLOT_W-1:0]  slot,
    output logic [fm_pkg::PHASE_W-1:0] phase,
    output logic [fm_pkg::ATT_W-1:0]   att,
    output logic [fm_pkg::FB_W-1:0]    fb
);

    logic [fm_pkg::SLOT_W-1:0] cnt;
    logic [fm_pkg::FREQ_W-1:0] freq_r [fm_pkg::NUM_SLOTS];
    logic [fm_pkg::ATT_W-1:0]  att_r  [fm_pkg::NUM_SLOTS];
    logic [fm_pkg::FB_W-1:0]   fb_r   [fm_pkg::NUM_SLOTS];
    logic [fm_pkg::ACC_W-1:0]  acc    [fm_pkg::NUM_SLOTS];

    // Settings, visible to the tick after the write
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < fm_pkg::NUM_SLOTS; i++) begin
                freq_r[i] <= '0;
                att_r[i]  <= '0;
                fb_r[i]   <= '0;
            end
        end else if (cfg_we) begin
            freq_r[cfg_slot] <= cfg_freq;
            att_r[cfg_slot]  <= cfg_att;
            fb_r[cfg_slot]   <= cfg_fb;
        end
    end

    // Slot counter, accumulators and registered slot outputs
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt   <= '0;
            slot  <= '0;
            phase <= '0;
            att   <= '0;
            fb    <= '0;
            for (int i = 0; i < fm_pkg::NUM_SLOTS; i++) begin
                acc[i] <= '0;
            end
        end else if (cen) begin
            slot  <= cnt;
            // Phase before this frame's increment
            phase <= acc[cnt][fm_pkg::ACC_W-1 -: fm_pkg::PHASE_W];
            att   <= att_r[cnt];
            fb    <= fb_r[cnt];
            acc[cnt] <= acc[cnt] + fm_pkg::ACC_W'(freq_r[cnt]);
            cnt   <= cnt + 1'b1;
        end
    end

endmodule

//--- source/fm_pkg.sv
/*
 * FM tone generator shared definitions
 * Slot count, field widths and the functions that fill
 * the log-sine and exponential ROMs at elaboration
 */
package fm_pkg;

    // Frame layout: modulator/carrier pairs for two voices
    localparam int NUM_SLOTS  = 4;
    localparam int SLOT_W     = 2;

    // Phase path
    localparam int FREQ_W     = 16;
    localparam int ACC_W      = 20;
    localparam int PHASE_W    = 10;

    // Level path, attenuation in 1/64 of a 6 dB step
    localparam int ATT_W      = 10;
    localparam int FB_W       = 3;
    localparam int LOG_W      = 12;
    localparam int OUT_W      = 14;
    localparam int SMP_W      = 16;

    // ROM geometry
    localparam int ROM_AW     = 8;
    localparam int MANT_W     = 10;

    // Ticks from phase entry to op_out
    localparam int OP_LATENCY = 5;

    localparam real PI = 3.14159265358979;

    // Quarter-wave log-sine, -log2(sin) at index midpoint, 1/256 units
    function automatic logic [LOG_W-1:0] logsin_entry(input int idx);
        real s;
        real v;
        s = $sin((real'(idx) + 0.5) * PI / 512.0);
        v = -$ln(s) / $ln(2.0) * 256.0;
        return LOG_W'($rtoi(v + 0.5));
    endfunction

    // Mantissa fraction of 2^(-idx/256), hidden bit worth 1024
    function automatic logic [MANT_W-1:0] exp_entry(input int idx);
        real v;
        int  r;
        v = $pow(2.0, -real'(idx) / 256.0) * 2048.0 - 1024.0;
        r = $rtoi(v + 0.5);
        // Index 0 would need the hidden bit itself
        if (r > 1023) begin
            r = 1023;
        end
        return MANT_W'(r);
    endfunction

endpackage

//--- verification/fm_core_sva.sv
/*
 * FM core timing assertions
 * Reset clears the sample pulse, the pulse is one clock wide and
 * the output slot steps once per tick once the pipeline is full
 */
`timescale 1ns/100ps

module fm_core_sva (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      cen,
    input logic                      sample_valid,
    input logic [fm_pkg::SLOT_W-1:0] op_slot
);

    // Ticks since reset, parks at 7
    logic [2:0] ticks;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ticks <= '0;
        end else if (cen && ticks != 3'd7) begin
            ticks <= ticks + 3'd1;
        end
    end

    a_valid_after_reset: assert property (@(posedge clk) !rst_n |=> !sample_valid)
        else $error("sample_valid high in the cycle after reset");

    a_valid_one_clock: assert property (@(posedge clk) disable iff (!rst_n)
        sample_valid |=> !sample_valid)
        else $error("sample_valid high on two consecutive clocks");

    // First real slot shows after tick 5, steady stepping from tick 6 on
    a_slot_steps: assert property (@(posedge clk) disable iff (!rst_n)
        (cen && ticks >= 3'd6) |=> (op_slot == $past(op_slot) + 2'd1))
        else $error("op_slot did not advance by one on a tick");

endmodule

//--- verification/fm_core_tb.sv
/*
 * Testbench for the two-voice FM core
 * LFSR stimulus, frame-level reference model, checks on every clock
 */
`timescale 1ns/100ps

module fm_core_tb;

    logic                            clk;
    logic                            rst_n;
    logic                            cen;
    logic                            cfg_we;
    logic [fm_pkg::SLOT_W-1:0]       cfg_slot;
    logic [fm_pkg::FREQ_W-1:0]       cfg_freq;
    logic [fm_pkg::ATT_W-1:0]        cfg_att;
    logic [fm_pkg::FB_W-1:0]         cfg_fb;
    logic signed [fm_pkg::SMP_W-1:0] sample;
    logic                            sample_valid;
    logic signed [fm_pkg::OUT_W-1:0] op_out;
    logic [fm_pkg::SLOT_W-1:0]       op_slot;

    // Frames per test, also sets the run limit
    int frames_per_test [6] = '{48, 64, 64, 32, 48, 64};

    // Model state per slot
    int m_acc  [fm_pkg::NUM_SLOTS];
    int m_freq [fm_pkg::NUM_SLOTS];
    int m_att  [fm_pkg::NUM_SLOTS];
    int m_fb   [fm_pkg::NUM_SLOTS];
    // Last and second-to-last output
    int m_h1   [fm_pkg::NUM_SLOTS];
    int m_h2   [fm_pkg::NUM_SLOTS];
    int exp_val_q [$];
    int exp_slot_q [$];
    int exp_smp_q [$];
    int shown_val;
    int shown_slot;
    int m_ticks;
    int smp_seen;
    int smp_total;
    int out_total;
    int err_op;
    int err_smp;
    int err_ctl;
    int cycle_count;
    logic [31:0] lfsr_state;
    string test_name;

    fm_core fm_core_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .cen         (cen),
        .cfg_we      (cfg_we),
        .cfg_slot    (cfg_slot),
        .cfg_freq    (cfg_freq),
        .cfg_att     (cfg_att),
        .cfg_fb      (cfg_fb),
        .sample      (sample),
        .sample_valid(sample_valid),
        .op_out      (op_out),
        .op_slot     (op_slot)
    );

    bind fm_core fm_core_sva fm_core_sva_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .cen         (cen),
        .sample_valid(sample_valid),
        .op_slot     (op_slot)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        logic        nb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            nb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], nb};
            r = {r[30:0], nb};
        end
        return r;
    endfunction

    // Mode 0 about 3 ticks in 4, mode 1 about 1 in 4
    function automatic logic pick_cen(input int mode);
        if (mode == 0) begin
            return take_bits(2) != 0;
        end else begin
            return take_bits(2) == 0;
        end
    endfunction

    function automatic int clip_sample(input int v);
        int hi;
        int lo;
        hi = (1 << (fm_pkg::SMP_W - 1)) - 1;
        lo = -(1 << (fm_pkg::SMP_W - 1));
        if (v > hi) begin
            return hi;
        end else if (v < lo) begin
            return lo;
        end
        return v;
    endfunction

    task automatic model_reset();
        for (int s = 0; s < fm_pkg::NUM_SLOTS; s++) begin
            m_acc[s]  = 0;
            m_freq[s] = 0;
            m_att[s]  = 0;
            m_fb[s]   = 0;
            m_h1[s]   = 0;
            m_h2[s]   = 0;
        end
        exp_val_q.delete();
        exp_slot_q.delete();
        exp_smp_q.delete();
        // Cleared outputs read as slot 0, value 0
        shown_val  = 0;
        shown_slot = 0;
        m_ticks    = 0;
        smp_seen   = 0;
    endtask

    // One slot entry, computed straight from the operator rules
    task automatic model_tick();
        int s;
        int ph;
        int md;
        int p;
        int idx;
        int tot;
        int mag;
        int outv;
        s  = m_ticks % fm_pkg::NUM_SLOTS;
        ph = m_acc[s] >> (fm_pkg::ACC_W - fm_pkg::PHASE_W);
        m_acc[s] = (m_acc[s] + m_freq[s]) & ((1 << fm_pkg::ACC_W) - 1);
        if (s % 2 == 1) begin
            // Modulator already ran this frame, h2 holds frame n-1
            md = (m_h2[s-1] >>> 1) & ((1 << fm_pkg::PHASE_W) - 1);
        end else if (m_fb[s] == 0) begin
            md = 0;
        end else begin
            md = ((m_h1[s] + m_h2[s]) >>> (10 - m_fb[s])) & ((1 << fm_pkg::PHASE_W) - 1);
        end
        p   = (ph + md) & ((1 << fm_pkg::PHASE_W) - 1);
        idx = p & ((1 << fm_pkg::ROM_AW) - 1);
        // Falling half of each half-wave reads the table backwards
        if ((p & (1 << fm_pkg::ROM_AW)) != 0) begin
            idx = ((1 << fm_pkg::ROM_AW) - 1) - idx;
        end
        tot = int'(fm_pkg::logsin_entry(idx)) + 4 * m_att[s];
        if (tot > (1 << fm_pkg::LOG_W) - 1) begin
            tot = (1 << fm_pkg::LOG_W) - 1;
        end
        mag  = (1024 + int'(fm_pkg::exp_entry(tot & 255))) >> (tot / 256 + 1);
        outv = ((p & (1 << (fm_pkg::PHASE_W - 1))) != 0) ? -mag : mag;
        m_h2[s] = m_h1[s];
        m_h1[s] = outv;
        exp_val_q.push_back(outv);
        exp_slot_q.push_back(s);
        if (s == fm_pkg::NUM_SLOTS - 1) begin
            exp_smp_q.push_back(clip_sample(m_h1[1] + outv));
        end
        m_ticks++;
    endtask

    // Inputs still hold what the last rising edge sampled
    task automatic check_edge();
        logic exp_valid;
        int   exp_smp;
        exp_valid = 1'b0;
        if (!rst_n) begin
            model_reset();
        end else begin
            if (cen) begin
                // Pulse on the tick after slot 3 was showing
                exp_valid = (shown_slot == fm_pkg::NUM_SLOTS - 1);
                model_tick();
                if (exp_val_q.size() > fm_pkg::OP_LATENCY) begin
                    shown_val  = exp_val_q.pop_front();
                    shown_slot = exp_slot_q.pop_front();
                    out_total++;
                end
            end
            // Write lands after this edge's tick
            if (cfg_we) begin
                m_freq[cfg_slot] = cfg_freq;
                m_att[cfg_slot]  = cfg_att;
                m_fb[cfg_slot]   = cfg_fb;
            end
        end
        assert (int'(op_out) == shown_val) else begin
            err_op++;
            $display("mismatch test=%s op_out slot %0d expected=%0d actual=%0d",
                     test_name, shown_slot, shown_val, op_out);
        end
        assert (int'(op_slot) == shown_slot) else begin
            err_ctl++;
            $display("mismatch test=%s op_slot expected=%0d actual=%0d",
                     test_name, shown_slot, op_slot);
        end
        assert (sample_valid == exp_valid) else begin
            err_ctl++;
            $display("mismatch test=%s sample_valid expected=%0b actual=%0b",
                     test_name, exp_valid, sample_valid);
        end
        // Slot 3 on show means its frame sample is already queued
        if (sample_valid && exp_valid) begin
            exp_smp = exp_smp_q.pop_front();
            smp_seen++;
            smp_total++;
            assert (int'(sample) == exp_smp) else begin
                err_smp++;
                $display("mismatch test=%s sample expected=%0d actual=%0d",
                         test_name, exp_smp, sample);
            end
        end
    endtask

    // Check the edge just passed, then drive the next inputs
    task automatic drive_cycle(input logic r, input logic c, input logic w,
                               input int s, input int f, input int a, input int b);
        @(negedge clk);
        check_edge();
        rst_n    = r;
        cen      = c;
        cfg_we   = w;
        cfg_slot = fm_pkg::SLOT_W'(s);
        cfg_freq = fm_pkg::FREQ_W'(f);
        cfg_att  = fm_pkg::ATT_W'(a);
        cfg_fb   = fm_pkg::FB_W'(b);
    endtask

    task automatic reset_dut();
        repeat (8) begin
            drive_cycle(1'b0, 1'b0, 1'b0, 0, 0, 0, 0);
        end
    endtask

    // fb_mode 0 off, 1 levels 1 to 7, 2 any level
    task automatic setup_slots(input int mod_base, input int mod_bits, input int car_base,
                               input int car_bits, input int fb_mode);
        int f;
        int a;
        int b;
        for (int s = 0; s < fm_pkg::NUM_SLOTS; s++) begin
            f = take_bits(16);
            if (s % 2 == 0) begin
                a = mod_base + take_bits(mod_bits);
            end else begin
                a = car_base + take_bits(car_bits);
            end
            if (fb_mode == 0) begin
                b = 0;
            end else if (fb_mode == 1) begin
                b = take_bits(3) % 7 + 1;
            end else begin
                b = take_bits(3);
            end
            drive_cycle(1'b1, 1'b0, 1'b1, s, f, a, b);
        end
    endtask

    // Until every frame's sample has come out
    task automatic run_frames(input int frames, input int cen_mode, input logic reconfig);
        logic c;
        logic w;
        int   s;
        int   f;
        int   a;
        int   b;
        while (smp_seen < frames) begin
            c = pick_cen(cen_mode);
            w = 1'b0;
            if (reconfig && take_bits(4) == 0) begin
                w = 1'b1;
            end
            s = take_bits(2);
            f = take_bits(16);
            a = take_bits(10);
            b = take_bits(3);
            drive_cycle(1'b1, c, w, s, f, a, b);
        end
    endtask

    task automatic run_test(input string name, input int frames, input int cen_mode,
                            input logic reconfig, input int mod_base, input int mod_bits,
                            input int car_base, input int car_bits, input int fb_mode);
        test_name = name;
        reset_dut();
        setup_slots(mod_base, mod_bits, car_base, car_bits, fb_mode);
        run_frames(frames, cen_mode, reconfig);
    endtask

    initial begin
        lfsr_state = 32'h35503fc3;
        rst_n      = 1'b0;
        cen        = 1'b0;
        cfg_we     = 1'b0;
        cfg_slot   = '0;
        cfg_freq   = '0;
        cfg_att    = '0;
        cfg_fb     = '0;
        err_op     = 0;
        err_smp    = 0;
        err_ctl    = 0;
        smp_total  = 0;
        out_total  = 0;
        test_name  = "reset";
        model_reset();
        // Modulators silenced, carriers plain sine
        run_test("pure_tone", frames_per_test[0], 0, 1'b0, 1023, 0, 0, 8, 0);
        run_test("carrier_mod", frames_per_test[1], 0, 1'b0, 0, 8, 0, 7, 0);
        run_test("feedback", frames_per_test[2], 0, 1'b0, 0, 8, 0, 8, 1);
        run_test("att_saturation", frames_per_test[3], 0, 1'b0, 960, 6, 960, 6, 2);
        // Loud carriers, sparse cen
        run_test("mixer_stall", frames_per_test[4], 1, 1'b0, 0, 8, 0, 0, 0);
        run_test("reconfig", frames_per_test[5], 0, 1'b1, 0, 9, 0, 9, 2);
        $display("Checked %0d outputs, %0d samples; errors op_out %0d sample %0d control %0d",
                 out_total, smp_total, err_op, err_smp, err_ctl);
        if (err_op + err_smp + err_ctl == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Watchdog at a cen rate of 1/8, drain and setup included
    initial begin
        int limit;
        limit = 0;
        foreach (frames_per_test[i]) begin
            limit += (frames_per_test[i] + 4) * fm_pkg::NUM_SLOTS * 8 + 32;
        end
        cycle_count = 0;
        while (cycle_count < limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", limit);
        $display("Result: FAILED");
        $finish;
    end

endmodule
